/* all.f */
source/mbus_pkg.sv
source/mbus_power_seq.sv
source/mbus_isolation.sv
source/mbus_layer_regs.sv
source/mbus_irq_msg.sv
source/mbus_tx_arbiter.sv
source/mbus_tx_serializer.sv
source/mbus_layer_top.sv
bench/mbus_layer_assertions.sv
bench/tb_mbus_layer.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mbus_layer
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
FAIL_MSG := Done: errors found

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_mbus_layer.sv */
`timescale 1ns/1ps

module tb_mbus_layer import mbus_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000;
	// Longest wait for a frame to start, covers a frame already on the line
	localparam int FRAME_WAIT = 200;

	logic             clk;
	logic             rst_n;
	logic             mbc_isolate;
	logic             sleep_req;
	logic             wakeup;
	logic [IRQ_N-1:0] irq;
	axil_req_t        axil_req;
	axil_rsp_t        axil_rsp;
	logic             mbus_frame;
	logic             mbus_dout;
	logic             lrc_sleepb;
	logic             lrc_clken;
	logic             lrc_resetb;
	logic             lrc_isolate;
	logic [31:0]      lcg_state;
	int               errors;
	int               checks;
	int               cycles;

	mbus_layer_top dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.mbc_isolate (mbc_isolate),
		.sleep_req   (sleep_req),
		.wakeup      (wakeup),
		.irq         (irq),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.mbus_frame  (mbus_frame),
		.mbus_dout   (mbus_dout),
		.lrc_sleepb  (lrc_sleepb),
		.lrc_clken   (lrc_clken),
		.lrc_resetb  (lrc_resetb),
		.lrc_isolate (lrc_isolate)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	//********************
	// Helpers
	//********************
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic check_power(input logic sleepb, input logic clken, input logic resetb,
		input logic isolate);
		check_bit("lrc_sleepb", lrc_sleepb, sleepb);
		check_bit("lrc_clken", lrc_clken, clken);
		check_bit("lrc_resetb", lrc_resetb, resetb);
		check_bit("lrc_isolate", lrc_isolate, isolate);
	endtask

	// Address and data offered together, b answers one cycle after the handshake
	task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = '1;
		axil_req.bready  = 1'b1;
		while (!(axil_rsp.awready && axil_rsp.wready)) begin
			@(negedge clk);
		end
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		check_bit("bvalid", axil_rsp.bvalid, 1'b1);
		check_word("bresp", 32'(axil_rsp.bresp), 32'(AXI_RESP_OKAY));
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		axil_req.rready  = 1'b1;
		while (!axil_rsp.arready) begin
			@(negedge clk);
		end
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		check_bit("rvalid", axil_rsp.rvalid, 1'b1);
		check_word("rresp", 32'(axil_rsp.rresp), 32'(AXI_RESP_OKAY));
		data = axil_rsp.rdata;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	// Called on a falling edge, samples one bit per falling edge
	task automatic capture_frame(input int max_wait, output logic found,
		output logic [MBUS_ADDR_W-1:0] addr, output logic [MBUS_DATA_W-1:0] data);
		logic [MBUS_FRAME_BITS-1:0] bits;
		int                         waited;
		bits   = '0;
		waited = 0;
		found  = 1'b0;
		while (!mbus_frame && waited < max_wait) begin
			@(negedge clk);
			waited++;
		end
		if (mbus_frame) begin
			found = 1'b1;
			for (int i = 0; i < MBUS_FRAME_BITS; i++) begin
				bits = {bits[MBUS_FRAME_BITS-2:0], mbus_dout};
				@(negedge clk);
			end
		end
		addr = bits[MBUS_FRAME_BITS-1 -: MBUS_ADDR_W];
		data = bits[MBUS_DATA_W-1:0];
	endtask

	task automatic expect_frame(input string what, input logic [MBUS_ADDR_W-1:0] exp_addr,
		input logic [MBUS_DATA_W-1:0] exp_data);
		logic                   found;
		logic [MBUS_ADDR_W-1:0] got_addr;
		logic [MBUS_DATA_W-1:0] got_data;
		capture_frame(FRAME_WAIT, found, got_addr, got_data);
		if (!found) begin
			report_failure({what, " did not appear on the serial line"});
		end else begin
			check_word({what, " address"}, 32'(got_addr), 32'(exp_addr));
			check_word({what, " data"}, got_data, exp_data);
		end
	endtask

	task automatic expect_no_frame(input string what, input int max_wait);
		logic                   found;
		logic [MBUS_ADDR_W-1:0] got_addr;
		logic [MBUS_DATA_W-1:0] got_data;
		capture_frame(max_wait, found, got_addr, got_data);
		if (found) begin
			report_failure({what, " appeared although none was expected"});
		end
	endtask

	task automatic post_host(input logic [MBUS_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic prio);
		axil_write(REG_CTRL, 32'(prio));
		axil_write(REG_TX_ADDR, 32'(addr));
		axil_write(REG_TX_DATA, data);
	endtask

	// Edge one cycle ahead of the data write, so both requests rise on one cycle
	task automatic post_with_irq_edge(input logic [IRQ_N-1:0] bits, input logic [31:0] data);
		@(negedge clk);
		irq = bits;
		axil_write(REG_TX_DATA, data);
		irq = '0;
	endtask

	//********************
	// Directed tests
	//********************
	task automatic test_reset_state();
		@(negedge clk);
		check_bit("mbus_frame", mbus_frame, 1'b0);
		check_bit("bvalid", axil_rsp.bvalid, 1'b0);
		check_bit("rvalid", axil_rsp.rvalid, 1'b0);
		check_power(1'b1, 1'b1, 1'b1, 1'b0);
	endtask

	task automatic test_host_message();
		logic [MBUS_ADDR_W-1:0] addr;
		logic [31:0]            data;
		logic [31:0]            status;
		addr = MBUS_ADDR_W'(next_random());
		data = next_random();
		axil_write(REG_TX_ADDR, 32'(addr));
		axil_write(REG_TX_DATA, data);
		expect_frame("host frame", addr, data);
		axil_read(REG_STATUS, status);
		check_word("STATUS", status, 32'd0);
	endtask

	task automatic test_irq_message();
		@(negedge clk);
		irq = 4'b0101;
		@(negedge clk);
		irq = '0;
		expect_frame("interrupt frame", IRQ_MSG_ADDR, 32'd5);
		expect_no_frame("second interrupt frame", 100);
	endtask

	task automatic test_arbitration();
		logic [MBUS_ADDR_W-1:0] addr;
		logic [31:0]            data;
		// Host served last, tie rule alone would pick the interrupt
		addr = MBUS_ADDR_W'(next_random());
		data = next_random();
		post_host(addr, data, 1'b0);
		expect_frame("host frame", addr, data);
		// Priority bit beats round robin
		addr = MBUS_ADDR_W'(next_random());
		data = next_random();
		axil_write(REG_CTRL, 32'd1);
		axil_write(REG_TX_ADDR, 32'(addr));
		post_with_irq_edge(4'b1000, data);
		expect_frame("priority host frame", addr, data);
		expect_frame("interrupt frame after host", IRQ_MSG_ADDR, 32'd8);
		// Equal priority after a host frame, interrupt goes first
		addr = MBUS_ADDR_W'(next_random());
		data = next_random();
		post_host(addr, data, 1'b0);
		expect_frame("host frame", addr, data);
		addr = MBUS_ADDR_W'(next_random());
		data = next_random();
		axil_write(REG_TX_ADDR, 32'(addr));
		post_with_irq_edge(4'b0010, data);
		expect_frame("round robin interrupt frame", IRQ_MSG_ADDR, 32'd2);
		expect_frame("host frame after interrupt", addr, data);
	endtask

	task automatic test_sleep_wake();
		logic [31:0] status;
		// Interrupt frame on the line, host message queued behind it
		@(negedge clk);
		irq = 4'b0001;
		@(negedge clk);
		irq = '0;
		while (!mbus_frame) begin
			@(negedge clk);
		end
		axil_write(REG_TX_DATA, next_random());
		axil_read(REG_STATUS, status);
		check_word("STATUS while queued", status, 32'd1);
		@(negedge clk);
		sleep_req = 1'b1;
		@(negedge clk);
		sleep_req = 1'b0;
		check_power(1'b1, 1'b1, 1'b1, 1'b1);
		@(negedge clk);
		check_power(1'b1, 1'b1, 1'b0, 1'b1);
		@(negedge clk);
		check_power(1'b1, 1'b0, 1'b0, 1'b1);
		@(negedge clk);
		check_power(1'b0, 1'b0, 1'b0, 1'b1);
		// Frame in flight finishes while the layer sleeps
		while (mbus_frame) begin
			@(negedge clk);
		end
		@(negedge clk);
		wakeup = 1'b1;
		@(negedge clk);
		wakeup = 1'b0;
		check_power(1'b1, 1'b0, 1'b0, 1'b1);
		@(negedge clk);
		check_power(1'b1, 1'b1, 1'b0, 1'b1);
		@(negedge clk);
		check_power(1'b1, 1'b1, 1'b1, 1'b1);
		@(negedge clk);
		check_power(1'b1, 1'b1, 1'b1, 1'b0);
		// Queued message went with the layer reset
		axil_read(REG_STATUS, status);
		check_word("STATUS", status, 32'd0);
		expect_no_frame("queued host frame", 100);
	endtask

	task automatic test_mbc_isolation();
		@(negedge clk);
		mbc_isolate = 1'b1;
		#1;
		check_power(1'b0, 1'b0, 1'b0, 1'b1);
		@(negedge clk);
		mbc_isolate = 1'b0;
		#1;
		check_power(1'b1, 1'b1, 1'b1, 1'b0);
	endtask

	//********************
	// Main sequence
	//********************
	initial begin
		lcg_state   = 32'h4f8a;
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		rst_n       = 1'b0;
		mbc_isolate = 1'b0;
		sleep_req   = 1'b0;
		wakeup      = 1'b0;
		irq         = '0;
		axil_req    = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset_state();
		test_host_message();
		test_irq_message();
		test_arbitration();
		test_sleep_wake();
		test_mbc_isolation();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* bench/mbus_layer_assertions.sv */
`timescale 1ns/1ps

module mbus_layer_assertions import mbus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic mbus_frame,
	input logic lrc_isolate,
	input logic lrc_resetb
);

	// High cycles of the frame so far
	logic [6:0] frame_len;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_len <= '0;
		end else if (mbus_frame) begin
			frame_len <= frame_len + 1'b1;
		end else begin
			frame_len <= '0;
		end
	end

	//********************
	// Framing
	//********************
	frame_len_a: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(mbus_frame) |-> frame_len == 7'(MBUS_FRAME_BITS))
		else $error("mbus_frame ended after %0d cycles", frame_len);

	frame_max_a: assert property (@(posedge clk) disable iff (!rst_n)
		frame_len <= 7'(MBUS_FRAME_BITS))
		else $error("mbus_frame high longer than one frame");

	// Acceptance happens one cycle before the frame rises
	frame_iso_a: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mbus_frame) |-> !$past(lrc_isolate))
		else $error("frame started while the layer was isolated");

	//********************
	// Power order
	//********************
	reset_iso_a: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(lrc_resetb) |-> $past(lrc_isolate))
		else $error("lrc_resetb released after isolation was already off");

endmodule

bind mbus_layer_top mbus_layer_assertions assertions_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.mbus_frame  (mbus_frame),
	.lrc_isolate (lrc_isolate),
	.lrc_resetb  (lrc_resetb)
);

/* source/mbus_layer_top.sv */
`timescale 1ns/1ps

module mbus_layer_top import mbus_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mbc_isolate,
	input  logic             sleep_req,
	input  logic             wakeup,
	input  logic [IRQ_N-1:0] irq,
	input  axil_req_t        axil_req,
	output axil_rsp_t        axil_rsp,
	output logic             mbus_frame,
	output logic             mbus_dout,
	output logic             lrc_sleepb,
	output logic             lrc_clken,
	output logic             lrc_resetb,
	output logic             lrc_isolate
);

	power_ctl_t power_uniso;
	power_ctl_t power;
	logic       reg_valid;
	tx_req_t    reg_req;
	logic       reg_sent;
	logic       irq_valid;
	tx_req_t    irq_req;
	logic       irq_sent;
	logic       tx_valid_uniso;
	tx_req_t    tx_req_uniso;
	logic       tx_valid;
	tx_req_t    tx_req;
	logic       tx_done;

	assign lrc_isolate = power.isolate;

	//********************
	// Power path
	//********************
	mbus_power_seq power_seq_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.sleep_req   (sleep_req),
		.wakeup      (wakeup),
		.power_uniso (power_uniso)
	);

	mbus_isolation isolation_i (
		.mbc_isolate    (mbc_isolate),
		.power_uniso    (power_uniso),
		.tx_valid_uniso (tx_valid_uniso),
		.tx_req_uniso   (tx_req_uniso),
		.power          (power),
		.sleepb         (lrc_sleepb),
		.clken          (lrc_clken),
		.resetb         (lrc_resetb),
		.tx_valid       (tx_valid),
		.tx_req         (tx_req)
	);

	//********************
	// Requesters
	//********************
	mbus_layer_regs layer_regs_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.layer_resetb (lrc_resetb),
		.axil_req     (axil_req),
		.axil_rsp     (axil_rsp),
		.req_valid    (reg_valid),
		.req          (reg_req),
		.sent         (reg_sent)
	);

	mbus_irq_msg irq_msg_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.layer_resetb (lrc_resetb),
		.irq          (irq),
		.req_valid    (irq_valid),
		.req          (irq_req),
		.sent         (irq_sent)
	);

	//********************
	// Transmit path
	//********************
	mbus_tx_arbiter tx_arbiter_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.reg_valid      (reg_valid),
		.reg_req        (reg_req),
		.reg_sent       (reg_sent),
		.irq_valid      (irq_valid),
		.irq_req        (irq_req),
		.irq_sent       (irq_sent),
		.tx_valid_uniso (tx_valid_uniso),
		.tx_req_uniso   (tx_req_uniso),
		.tx_done        (tx_done)
	);

	mbus_tx_serializer tx_serializer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.tx_valid   (tx_valid),
		.tx_req     (tx_req),
		.tx_done    (tx_done),
		.mbus_frame (mbus_frame),
		.mbus_dout  (mbus_dout)
	);

endmodule

/* source/mbus_tx_serializer.sv */
`timescale 1ns/1ps

module mbus_tx_serializer import mbus_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    tx_valid,
	input  tx_req_t tx_req,
	output logic    tx_done,
	output logic    mbus_frame,
	output logic    mbus_dout
);

	logic                       busy;
	logic                       done_q;
	logic                       accept;
	logic                       last_bit;
	logic [FRAME_CNT_W-1:0]     bit_cnt;
	logic [MBUS_FRAME_BITS-1:0] shift_q;

	//********************
	// Frame control
	//********************
	// Idle includes the done cycle
	assign accept   = tx_valid && !busy;
	assign last_bit = (bit_cnt == FRAME_CNT_W'(MBUS_FRAME_BITS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			done_q  <= 1'b0;
			bit_cnt <= '0;
		end else begin
			done_q <= 1'b0;
			if (accept) begin
				busy    <= 1'b1;
				bit_cnt <= '0;
			end else if (busy) begin
				bit_cnt <= bit_cnt + 1'b1;
				// Done lands one cycle after the last bit
				if (last_bit) begin
					busy   <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	//********************
	// Shift register
	//********************
	// Address leads, MSB first
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_q <= {tx_req.addr, tx_req.data};
		end else if (busy) begin
			shift_q <= {shift_q[MBUS_FRAME_BITS-2:0], 1'b0};
		end
	end

	assign mbus_frame = busy;
	// Line rests low between frames
	assign mbus_dout  = busy && shift_q[MBUS_FRAME_BITS-1];
	assign tx_done    = done_q;

endmodule

/* source/mbus_tx_arbiter.sv */
`timescale 1ns/1ps

module mbus_tx_arbiter import mbus_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    reg_valid,
	input  tx_req_t reg_req,
	output logic    reg_sent,
	input  logic    irq_valid,
	input  tx_req_t irq_req,
	output logic    irq_sent,
	output logic    tx_valid_uniso,
	output tx_req_t tx_req_uniso,
	input  logic    tx_done
);

	logic grant_active;
	// 1 selects the interrupt requester
	logic grant_irq;
	logic last_irq;
	logic pick_irq;
	logic sel_valid;

	//********************
	// Selection
	//********************
	// Priority bit first, then the one not served last
	always_comb begin
		if (irq_valid && reg_valid) begin
			if (irq_req.prio != reg_req.prio) begin
				pick_irq = irq_req.prio;
			end else begin
				pick_irq = !last_irq;
			end
		end else begin
			pick_irq = irq_valid;
		end
	end

	assign sel_valid = grant_irq ? irq_valid : reg_valid;

	// Serializer is busy for as long as a grant is held
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_active <= 1'b0;
			grant_irq    <= 1'b0;
			last_irq     <= 1'b0;
		end else if (!grant_active) begin
			if (irq_valid || reg_valid) begin
				grant_active <= 1'b1;
				grant_irq    <= pick_irq;
			end
		end else if (tx_done) begin
			grant_active <= 1'b0;
			last_irq     <= grant_irq;
		end else if (!sel_valid) begin
			// Requester wiped by layer reset
			grant_active <= 1'b0;
		end
	end

	//********************
	// Transmit side
	//********************
	// Dropped in the done cycle so the frame is not sent twice
	assign tx_valid_uniso = grant_active && sel_valid && !tx_done;
	assign tx_req_uniso   = grant_irq ? irq_req : reg_req;
	assign reg_sent       = grant_active && tx_done && !grant_irq;
	assign irq_sent       = grant_active && tx_done && grant_irq;

endmodule

/* source/mbus_irq_msg.sv */
`timescale 1ns/1ps

module mbus_irq_msg import mbus_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             layer_resetb,
	input  logic [IRQ_N-1:0] irq,
	output logic             req_valid,
	output tx_req_t          req,
	input  logic             sent
);

	logic [IRQ_N-1:0] irq_q;
	logic [IRQ_N-1:0] edges;
	logic [IRQ_N-1:0] pend;
	// Bits carried by the message in flight
	logic [IRQ_N-1:0] snap;
	logic             in_flight;

	//********************
	// Edge capture
	//********************
	assign edges = irq & ~irq_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_q <= '0;
		end else begin
			irq_q <= irq;
		end
	end

	//********************
	// Message request
	//********************
	always_ff @(posedge clk) begin
		if (!rst_n || !layer_resetb) begin
			pend      <= '0;
			snap      <= '0;
			in_flight <= 1'b0;
		end else if (in_flight && sent) begin
			// Late edges survive the clear
			pend      <= (pend & ~snap) | edges;
			in_flight <= 1'b0;
		end else begin
			pend <= pend | edges;
			if (!in_flight && (pend != '0)) begin
				snap      <= pend;
				in_flight <= 1'b1;
			end
		end
	end

	assign req_valid = in_flight;
	// Interrupt messages never claim priority
	assign req = '{addr: IRQ_MSG_ADDR, data: MBUS_DATA_W'(snap), prio: 1'b0};

endmodule

/* source/mbus_layer_regs.sv */
`timescale 1ns/1ps

module mbus_layer_regs import mbus_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      layer_resetb,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output logic      req_valid,
	output tx_req_t   req,
	input  logic      sent
);

	// Write channel holding registers
	logic                    aw_full;
	logic [AXI_ADDR_W-1:0]   aw_addr;
	logic                    w_full;
	logic [AXI_DATA_W-1:0]   w_data;
	logic [AXI_DATA_W/8-1:0] w_strb;
	logic                    aw_hs;
	logic                    w_hs;
	logic                    wr_en;
	logic [AXI_ADDR_W-1:0]   wr_addr;
	logic [AXI_DATA_W-1:0]   wr_data;
	logic [AXI_DATA_W/8-1:0] wr_strb;
	logic [AXI_DATA_W-1:0]   wr_val;
	logic                    bvalid;
	// Read channel
	logic                    rvalid;
	logic [AXI_DATA_W-1:0]   rdata;
	// Message registers
	logic [MBUS_ADDR_W-1:0]  tx_addr;
	logic [MBUS_DATA_W-1:0]  tx_data;
	logic                    tx_prio;
	logic                    tx_pend;

	// Current contents of one register
	function automatic logic [AXI_DATA_W-1:0] reg_value(input logic [AXI_ADDR_W-1:0] addr);
		logic [AXI_DATA_W-1:0] val;
		val = '0;
		case (addr)
			REG_TX_ADDR: val[MBUS_ADDR_W-1:0] = tx_addr;
			REG_TX_DATA: val = tx_data;
			REG_CTRL:    val[0] = tx_prio;
			REG_STATUS:  val[0] = tx_pend;
			default:     val = '0;
		endcase
		return val;
	endfunction

	//********************
	// Write channel
	//********************
	assign aw_hs = axil_req.awvalid && axil_rsp.awready;
	assign w_hs  = axil_req.wvalid && axil_rsp.wready;
	// Address and data may arrive in either order
	assign wr_en   = (aw_full || aw_hs) && (w_full || w_hs);
	assign wr_addr = aw_full ? aw_addr : axil_req.awaddr;
	assign wr_data = w_full ? w_data : axil_req.wdata;
	assign wr_strb = w_full ? w_strb : axil_req.wstrb;

	// Byte lanes without strobe keep their old value
	always_comb begin
		wr_val = reg_value(wr_addr);
		for (int i = 0; i < AXI_DATA_W/8; i++) begin
			if (wr_strb[i]) begin
				wr_val[8*i +: 8] = wr_data[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			aw_full <= 1'b0;
			w_full  <= 1'b0;
			bvalid  <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			if (aw_hs) begin
				aw_addr <= axil_req.awaddr;
			end
			if (w_hs) begin
				w_data <= axil_req.wdata;
				w_strb <= axil_req.wstrb;
			end
			// Response one cycle after both halves are in
			if (wr_en) begin
				aw_full <= 1'b0;
				w_full  <= 1'b0;
				bvalid  <= 1'b1;
			end else begin
				aw_full <= aw_full || aw_hs;
				w_full  <= w_full || w_hs;
				if (bvalid && axil_req.bready) begin
					bvalid <= 1'b0;
				end
			end
			//********************
			// Read channel
			//********************
			if (axil_req.arvalid && axil_rsp.arready) begin
				rvalid <= 1'b1;
				rdata  <= reg_value(axil_req.araddr);
			end else if (rvalid && axil_req.rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// One write and one read in flight at most
	always_comb begin
		axil_rsp         = '0;
		axil_rsp.awready = !aw_full && !bvalid;
		axil_rsp.wready  = !w_full && !bvalid;
		axil_rsp.bvalid  = bvalid;
		axil_rsp.bresp   = AXI_RESP_OKAY;
		axil_rsp.arready = !rvalid;
		axil_rsp.rvalid  = rvalid;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = AXI_RESP_OKAY;
	end

	//********************
	// Message registers
	//********************
	// Layer reset wipes any queued host message
	always_ff @(posedge clk) begin
		if (!rst_n || !layer_resetb) begin
			tx_addr <= '0;
			tx_data <= '0;
			tx_prio <= 1'b0;
			tx_pend <= 1'b0;
		end else begin
			if (sent) begin
				tx_pend <= 1'b0;
			end
			if (wr_en) begin
				case (wr_addr)
					REG_TX_ADDR: tx_addr <= wr_val[MBUS_ADDR_W-1:0];
					REG_CTRL:    tx_prio <= wr_val[0];
					// Data write launches the message
					REG_TX_DATA: begin
						tx_data <= wr_val;
						tx_pend <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	assign req_valid = tx_pend;
	assign req       = '{addr: tx_addr, data: tx_data, prio: tx_prio};

endmodule

/* source/mbus_isolation.sv */
`timescale 1ns/1ps

module mbus_isolation import mbus_pkg::*; (
	input  logic       mbc_isolate,
	input  power_ctl_t power_uniso,
	input  logic       tx_valid_uniso,
	input  tx_req_t    tx_req_uniso,
	output power_ctl_t power,
	output logic       sleepb,
	output logic       clken,
	output logic       resetb,
	output logic       tx_valid,
	output tx_req_t    tx_req
);

	//********************
	// Controller isolation
	//********************
	// An isolated controller leaves the layer in its safe state
	always_comb begin
		if (mbc_isolate) begin
			power.sleep   = 1'b1;
			power.clkenb  = 1'b1;
			power.reset   = 1'b1;
			power.isolate = 1'b1;
		end else begin
			power = power_uniso;
		end
	end

	// Active low copies for the layer
	assign sleepb = ~power.sleep;
	assign clken  = ~power.clkenb;
	// Also serves as the layer reset
	assign resetb = ~power.reset;

	//********************
	// Layer isolation
	//********************
	// Requests are held off, requesters keep them pending
	always_comb begin
		if (power.isolate) begin
			tx_valid = 1'b0;
			tx_req   = '0;
		end else begin
			tx_valid = tx_valid_uniso;
			tx_req   = tx_req_uniso;
		end
	end

endmodule

/* source/mbus_power_seq.sv */
`timescale 1ns/1ps

module mbus_power_seq import mbus_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       sleep_req,
	input  logic       wakeup,
	output power_ctl_t power_uniso
);

	// Four steps down, asleep, four steps back up
	typedef enum logic [3:0] {
		ST_AWAKE,
		ST_SLP_ISO,
		ST_SLP_RST,
		ST_SLP_CLK,
		ST_SLP_SLEEP,
		ST_ASLEEP,
		ST_WAK_SLEEP,
		ST_WAK_CLK,
		ST_WAK_RST,
		ST_WAK_ISO
	} state_t;

	state_t state;
	state_t state_nxt;

	//********************
	// Sequencing
	//********************
	always_comb begin
		state_nxt = state;
		case (state)
			// Only the two rest states listen to requests
			ST_AWAKE: begin
				if (sleep_req) begin
					state_nxt = ST_SLP_ISO;
				end
			end
			ST_SLP_ISO:   state_nxt = ST_SLP_RST;
			ST_SLP_RST:   state_nxt = ST_SLP_CLK;
			ST_SLP_CLK:   state_nxt = ST_SLP_SLEEP;
			ST_SLP_SLEEP: state_nxt = ST_ASLEEP;
			ST_ASLEEP: begin
				if (wakeup) begin
					state_nxt = ST_WAK_SLEEP;
				end
			end
			ST_WAK_SLEEP: state_nxt = ST_WAK_CLK;
			ST_WAK_CLK:   state_nxt = ST_WAK_RST;
			ST_WAK_RST:   state_nxt = ST_WAK_ISO;
			default:      state_nxt = ST_AWAKE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_AWAKE;
		end else begin
			state <= state_nxt;
		end
	end

	//********************
	// Control decode
	//********************
	// Isolate first and last, sleep innermost
	always_comb begin
		power_uniso = '0;
		case (state)
			ST_SLP_ISO:   power_uniso = '{sleep: 1'b0, clkenb: 1'b0, reset: 1'b0, isolate: 1'b1};
			ST_SLP_RST:   power_uniso = '{sleep: 1'b0, clkenb: 1'b0, reset: 1'b1, isolate: 1'b1};
			ST_SLP_CLK:   power_uniso = '{sleep: 1'b0, clkenb: 1'b1, reset: 1'b1, isolate: 1'b1};
			ST_SLP_SLEEP: power_uniso = '1;
			ST_ASLEEP:    power_uniso = '1;
			// Wake releases sleep first
			ST_WAK_SLEEP: power_uniso = '{sleep: 1'b0, clkenb: 1'b1, reset: 1'b1, isolate: 1'b1};
			ST_WAK_CLK:   power_uniso = '{sleep: 1'b0, clkenb: 1'b0, reset: 1'b1, isolate: 1'b1};
			ST_WAK_RST:   power_uniso = '{sleep: 1'b0, clkenb: 1'b0, reset: 1'b0, isolate: 1'b1};
			default:      power_uniso = '0;
		endcase
	end

endmodule

/* source/mbus_pkg.sv */
package mbus_pkg;

	//********************
	// Message geometry
	//********************
	localparam int MBUS_ADDR_W = 8;
	localparam int MBUS_DATA_W = 32;
	// One frame carries the address followed by the data
	localparam int MBUS_FRAME_BITS = MBUS_ADDR_W + MBUS_DATA_W;
	// Bit counter width for one frame
	localparam int FRAME_CNT_W = $clog2(MBUS_FRAME_BITS);

	// Interrupt inputs and the address their messages go to
	localparam int IRQ_N = 4;
	localparam logic [MBUS_ADDR_W-1:0] IRQ_MSG_ADDR = 8'hF0;

	//********************
	// Host register map
	//********************
	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;
	localparam logic [AXI_ADDR_W-1:0] REG_TX_ADDR = 4'h0;
	localparam logic [AXI_ADDR_W-1:0] REG_TX_DATA = 4'h4;
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 4'h8;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'hC;
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// Outgoing message, address sits in the upper bits
	typedef struct packed {
		logic [MBUS_ADDR_W-1:0] addr;
		logic [MBUS_DATA_W-1:0] data;
		logic                   prio;
	} tx_req_t;

	// Layer power controls, all active high
	typedef struct packed {
		logic sleep;
		logic clkenb;
		logic reset;
		logic isolate;
	} power_ctl_t;

	// AXI4-Lite master to slave
	typedef struct packed {
		logic                    awvalid;
		logic [AXI_ADDR_W-1:0]   awaddr;
		logic                    wvalid;
		logic [AXI_DATA_W-1:0]   wdata;
		logic [AXI_DATA_W/8-1:0] wstrb;
		logic                    bready;
		logic                    arvalid;
		logic [AXI_ADDR_W-1:0]   araddr;
		logic                    rready;
	} axil_req_t;

	// AXI4-Lite slave to master
	typedef struct packed {
		logic                  awready;
		logic                  wready;
		logic                  bvalid;
		logic [1:0]            bresp;
		logic                  arready;
		logic                  rvalid;
		logic [AXI_DATA_W-1:0] rdata;
		logic [1:0]            rresp;
	} axil_rsp_t;

endpackage
